//--- flist.f
hdl/sb_pkg.sv
hdl/store_align.sv
hdl/store_buffer.sv
hdl/load_forward.sv
hdl/data_ram.sv
hdl/store_path_top.sv
sim/store_path_assert.sv
sim/store_path_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the store path testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
    --top-module store_path_tb -o store_path_sim \
    && ./obj_dir/store_path_sim +verilator+error+limit+100 | tee /dev/stderr \
    | grep -qF "=== PASS ===" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- sim/store_path_tb.sv
module store_path_tb
    import sb_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CYCLES = 3000;  // Tests need about 500 cycles.

    logic        clk;
    logic        rst;
    logic        flush;
    logic        st_valid;
    st_req_t     st_req;
    logic        st_ready;
    logic        st_misaligned;
    logic        drain_hold;
    logic        ld_valid;
    logic [31:0] ld_addr;
    logic        ld_rsp_valid;
    logic [31:0] ld_rdata;
    logic        sb_full;

    sb_entry_t   model_q [$];            // Pending stores, oldest first.
    logic [31:0] model_ram [RAM_WORDS];
    string       cur_test;
    int          errors = 0;
    int          cycles = 0;
    logic        taken;
    logic        exp_rsp_valid;
    logic [31:0] exp_rdata;
    logic [31:0] last_rdata;

    store_path_top uut (
        .clk(clk), .rst(rst), .flush(flush),
        .st_valid(st_valid), .st_req(st_req), .st_ready(st_ready),
        .st_misaligned(st_misaligned), .drain_hold(drain_hold),
        .ld_valid(ld_valid), .ld_addr(ld_addr),
        .ld_rsp_valid(ld_rsp_valid), .ld_rdata(ld_rdata), .sb_full(sb_full)
    );

    bind store_buffer store_path_assert u_assert (
        .clk(clk), .rst(rst), .flush(flush), .push_valid(push_valid),
        .push_ready(push_ready), .drain_valid(drain_valid),
        .drain_ready(drain_ready), .full(full), .cnt(cnt_q)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("ERROR: run stopped, no progress after %0d cycles", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     cur_test, what, expected, actual);
        end
    endtask

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic logic is_misaligned(st_req_t req);
        if (req.size == ST_HALF) return req.addr[0];
        if (req.size == ST_WORD) return req.addr[1:0] != 2'b00;
        return 1'b0;
    endfunction

    function automatic sb_entry_t make_entry(st_req_t req);
        sb_entry_t e;
        int        nbytes;
        int        lane;
        nbytes  = (req.size == ST_BYTE) ? 1 : (req.size == ST_HALF) ? 2 : 4;
        e       = '0;
        e.waddr = req.addr[31:2];
        e.valid = 1'b1;
        for (int k = 0; k < nbytes; k++) begin
            lane = int'(req.addr[1:0]) + k;  // Byte k of the data lands here.
            e.strb[lane]        = 1'b1;
            e.data[8*lane +: 8] = req.data[8*k +: 8];
        end
        return e;
    endfunction

    // RAM word with the pending bytes laid over it in age order.
    function automatic logic [31:0] expected_load(logic [31:0] addr);
        logic [31:0] w;
        w = model_ram[addr[RAM_IDX_W+1:2]];
        foreach (model_q[i]) begin
            for (int b = 0; b < 4; b++) begin
                if (model_q[i].waddr == addr[31:2] && model_q[i].strb[b]) begin
                    w[8*b +: 8] = model_q[i].data[8*b +: 8];
                end
            end
        end
        return w;
    endfunction

    // One clock. Inputs were set at the falling edge, the model follows the rising one.
    task automatic step();
        logic      full_now;
        logic      accept;
        logic      bad;
        sb_entry_t e;
        #1;
        full_now = (model_q.size() == SB_SIZE);
        accept   = st_valid && !full_now;
        bad      = accept && is_misaligned(st_req);
        check_value("st_ready", 32'(!full_now), 32'(st_ready));
        check_value("sb_full", 32'(full_now), 32'(sb_full));
        check_value("st_misaligned", 32'(bad), 32'(st_misaligned));
        exp_rsp_valid = ld_valid;
        if (ld_valid) exp_rdata = expected_load(ld_addr);
        if (!drain_hold && model_q.size() > 0) begin
            e = model_q.pop_front();  // Oldest entry written to the RAM.
            for (int b = 0; b < 4; b++) begin
                if (e.strb[b]) model_ram[e.waddr[RAM_IDX_W-1:0]][8*b +: 8] = e.data[8*b +: 8];
            end
        end
        if (flush) model_q.delete();
        else if (accept && !bad) model_q.push_back(make_entry(st_req));
        taken = accept;
        @(negedge clk);
        check_value("ld_rsp_valid", 32'(exp_rsp_valid), 32'(ld_rsp_valid));
        if (exp_rsp_valid) begin
            check_value("ld_rdata", exp_rdata, ld_rdata);
            last_rdata = ld_rdata;
        end
    endtask

    // ------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------
    task automatic set_store(input logic [31:0] addr, input logic [31:0] data,
                             input st_size_e size);
        st_valid    = 1'b1;
        st_req.addr = addr;
        st_req.data = data;
        st_req.size = size;
    endtask

    task automatic offer_store(input logic [31:0] addr, input logic [31:0] data,
                               input st_size_e size);
        set_store(addr, data, size);
        taken = 1'b0;
        while (!taken) step();
        st_valid = 1'b0;
    endtask

    task automatic do_load(input logic [31:0] addr);
        ld_valid = 1'b1;
        ld_addr  = addr;
        step();  // Response is checked at the end of this cycle.
        ld_valid = 1'b0;
    endtask

    task automatic drain_all();
        drain_hold = 1'b0;
        while (model_q.size() > 0) step();
        repeat (SB_SIZE) step();
    endtask

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------
    task automatic test_reset_backpressure();
        cur_test = "reset_backpressure";
        check_value("st_ready after reset", 1, 32'(st_ready));
        check_value("sb_full after reset", 0, 32'(sb_full));
        drain_hold = 1'b1;
        for (int i = 0; i < SB_SIZE; i++) begin
            offer_store(32'h40 + 32'(4 * i), 32'h1000_0000 + 32'(i), ST_WORD);
        end
        step();
        check_value("sb_full with four held", 1, 32'(sb_full));
        set_store(32'h50, 32'h5555_5555, ST_WORD);
        taken = 1'b0;
        repeat (3) step();
        check_value("st_ready while held full", 0, 32'(st_ready));
        drain_hold = 1'b0;
        while (!taken) step();
        st_valid = 1'b0;
        drain_all();
        do_load(32'h50);
        check_value("fifth store in RAM", 32'h5555_5555, last_rdata);
    endtask

    task automatic test_forward();
        cur_test = "forward";
        offer_store(32'h80, 32'hA1B2_C3D4, ST_WORD);
        drain_all();
        drain_hold = 1'b1;
        offer_store(32'h81, 32'h11, ST_BYTE);
        offer_store(32'h82, 32'h2233, ST_HALF);
        offer_store(32'h82, 32'h44, ST_BYTE);  // Newer byte over the half.
        offer_store(32'h84, 32'h5566_7788, ST_WORD);
        do_load(32'h80);
        check_value("merged word", 32'h2244_11D4, last_rdata);
        do_load(32'h83);
        do_load(32'h84);
        do_load(32'h88);
        check_value("unwritten word", 32'h0, last_rdata);
    endtask

    task automatic test_drain();
        cur_test = "drain";
        drain_all();
        do_load(32'h80);
        check_value("merged word in RAM", 32'h2244_11D4, last_rdata);
        do_load(32'h84);
        check_value("word in RAM", 32'h5566_7788, last_rdata);
    endtask

    task automatic test_flush();
        cur_test   = "flush";
        drain_hold = 1'b1;
        offer_store(32'h80, 32'hDEAD_BEEF, ST_WORD);
        offer_store(32'h86, 32'h9999, ST_HALF);
        set_store(32'h8C, 32'h7777_7777, ST_WORD);  // Consumed by the flush cycle.
        flush = 1'b1;
        step();
        flush    = 1'b0;
        st_valid = 1'b0;
        do_load(32'h80);
        check_value("old word after flush", 32'h2244_11D4, last_rdata);
        do_load(32'h84);
        do_load(32'h8C);
        check_value("dropped store", 32'h0, last_rdata);
        for (int i = 0; i < SB_SIZE; i++) begin
            offer_store(32'hC0 + 32'(4 * i), 32'(i + 1), ST_WORD);
        end
        step();
        check_value("sb_full after refill", 1, 32'(sb_full));
        drain_all();
    endtask

    task automatic test_misaligned();
        cur_test   = "misaligned";
        drain_hold = 1'b0;
        offer_store(32'h91, 32'hAAAA, ST_HALF);
        offer_store(32'h86, 32'hBBBB_BBBB, ST_WORD);
        offer_store(32'h8F, 32'hCCCC_CCCC, ST_WORD);
        drain_all();
        do_load(32'h90);
        check_value("word 0x90", 32'h0, last_rdata);
        do_load(32'h84);
        check_value("word 0x84", 32'h5566_7788, last_rdata);
        do_load(32'h8C);
        check_value("word 0x8C", 32'h0, last_rdata);
    endtask

    task automatic test_random();
        cur_test = "random";
        for (int n = 0; n < 200; n++) begin
            if ($urandom_range(0, 1) == 1) begin
                set_store(32'h100 + $urandom_range(0, 31), $urandom,
                          st_size_e'(2'($urandom_range(0, 2))));
            end
            ld_valid = 1'($urandom_range(0, 1));
            ld_addr  = 32'h100 + $urandom_range(0, 31);
            if ($urandom_range(0, 3) == 0) drain_hold = ~drain_hold;
            step();
            st_valid = 1'b0;
            ld_valid = 1'b0;
        end
        drain_all();
        for (int w = 0; w < 8; w++) begin
            do_load(32'h100 + 32'(4 * w));
        end
    endtask

    initial begin
        void'($urandom(74));
        rst           = 1'b1;
        flush         = 1'b0;
        st_valid      = 1'b0;
        st_req        = '0;
        drain_hold    = 1'b0;
        ld_valid      = 1'b0;
        ld_addr       = '0;
        taken         = 1'b0;
        exp_rsp_valid = 1'b0;
        exp_rdata     = '0;
        last_rdata    = '0;
        foreach (model_ram[w]) model_ram[w] = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_backpressure();
        test_forward();
        test_drain();
        test_flush();
        test_misaligned();
        test_random();
        errors += uut.u_sb.u_assert.fail_cnt;
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- sim/store_path_assert.sv
module store_path_assert
    import sb_pkg::*;
(
    input logic                clk,
    input logic                rst,
    input logic                flush,
    input logic                push_valid,
    input logic                push_ready,
    input logic                drain_valid,
    input logic                drain_ready,
    input logic                full,
    input logic [SB_CNT_W-1:0] cnt
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;  // Added to the error total at the end of the run.

    logic pop;
    logic push;

    assign pop  = drain_valid & drain_ready;
    assign push = push_valid & push_ready & ~flush;

    cnt_bound: assert property (@(posedge clk) disable iff (rst)
        cnt <= SB_CNT_W'(SB_SIZE))
        else begin
            $error("store buffer count above its size");
            fail_cnt++;
        end

    // The oldest slot is valid exactly when the count is nonzero.
    valid_matches_cnt: assert property (@(posedge clk) disable iff (rst)
        drain_valid == (cnt != '0))
        else begin
            $error("store buffer oldest valid bit disagrees with its count");
            fail_cnt++;
        end

    flush_empties: assert property (@(posedge clk) disable iff (rst)
        flush |=> (cnt == '0) && !drain_valid)
        else begin
            $error("store buffer not empty after flush");
            fail_cnt++;
        end

    // Only a pop or a flush leaves the full state.
    full_holds: assert property (@(posedge clk) disable iff (rst)
        full && !pop && !flush |=> full)
        else begin
            $error("store buffer left full without a pop");
            fail_cnt++;
        end

    push_counts: assert property (@(posedge clk) disable iff (rst)
        push && !pop |=> cnt == $past(cnt) + SB_CNT_W'(1))
        else begin
            $error("store buffer count missed a push");
            fail_cnt++;
        end

endmodule

//--- hdl/store_path_top.sv
module store_path_top
    import sb_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,

    // Store port.
    input  logic        st_valid,
    input  st_req_t     st_req,
    output logic        st_ready,
    output logic        st_misaligned,

    input  logic        drain_hold,  // Holds the buffer drain.

    // Load port.
    input  logic        ld_valid,
    input  logic [31:0] ld_addr,
    output logic        ld_rsp_valid,
    output logic [31:0] ld_rdata,

    output logic        sb_full
);

    logic      push_valid;
    logic      push_ready;
    sb_entry_t push_entry;

    logic      drain_valid;
    logic      drain_ready;
    sb_entry_t drain_entry;

    sb_snap_t    snap;
    logic        ram_wr_en;
    logic [31:0] ram_rdata;

    assign drain_ready = ~drain_hold;
    assign ram_wr_en   = drain_valid & ~drain_hold;  // Same edge as the pop.

    // ------------------------------------------------------------
    // Store path
    // ------------------------------------------------------------
    store_align u_align (
        .st_valid      (st_valid),
        .st_req        (st_req),
        .st_ready      (st_ready),
        .st_misaligned (st_misaligned),
        .push_valid    (push_valid),
        .push_entry    (push_entry),
        .push_ready    (push_ready)
    );

    store_buffer u_sb (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .push_valid  (push_valid),
        .push_entry  (push_entry),
        .push_ready  (push_ready),
        .drain_valid (drain_valid),
        .drain_entry (drain_entry),
        .drain_ready (drain_ready),
        .snap        (snap),
        .full        (sb_full)
    );

    data_ram u_ram (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (ram_wr_en),
        .wr_entry (drain_entry),
        .rd_addr  (ld_addr),
        .rd_data  (ram_rdata)
    );

    // ------------------------------------------------------------
    // Load path
    // ------------------------------------------------------------
    load_forward u_fwd (
        .clk          (clk),
        .rst          (rst),
        .ld_valid     (ld_valid),
        .ld_addr      (ld_addr),
        .snap         (snap),
        .ram_rdata    (ram_rdata),
        .ld_rsp_valid (ld_rsp_valid),
        .ld_rdata     (ld_rdata)
    );

endmodule

//--- hdl/data_ram.sv
module data_ram
    import sb_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_en,
    input  sb_entry_t   wr_entry,
    input  logic [31:0] rd_addr,
    output logic [31:0] rd_data
);

    logic [31:0] mem [RAM_WORDS];

    logic [RAM_IDX_W-1:0] wr_idx;
    logic [RAM_IDX_W-1:0] rd_idx;

    // Upper word-address bits wrap onto the small array.
    assign wr_idx = wr_entry.waddr[RAM_IDX_W-1:0];
    assign rd_idx = rd_addr[RAM_IDX_W+1:2];  // Byte address to word index.

    // ------------------------------------------------------------
    // Byte-strobe write port
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < RAM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_entry.strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_entry.data[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------
    // Read before write when both address the same word.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_idx];
    end

endmodule

//--- hdl/load_forward.sv
module load_forward
    import sb_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        ld_valid,
    input  logic [31:0] ld_addr,
    input  sb_snap_t    snap,
    input  logic [31:0] ram_rdata,
    output logic        ld_rsp_valid,
    output logic [31:0] ld_rdata
);

    logic [29:0] ld_waddr;
    logic [3:0]  hit;
    logic [31:0] fwd_data;

    logic [3:0]  hit_q;
    logic [31:0] fwd_q;
    logic        rsp_valid_q;

    assign ld_waddr = ld_addr[31:2];  // Byte offset ignored.

    // ------------------------------------------------------------
    // Buffer search in the request cycle
    // ------------------------------------------------------------
    // Each lane takes the newest entry that wrote it.
    always_comb begin
        hit      = 4'b0000;
        fwd_data = '0;
        for (int b = 0; b < 4; b++) begin
            for (int i = SB_SIZE - 1; i >= 0; i--) begin
                if (!hit[b] && snap[i].valid && snap[i].strb[b] &&
                    (snap[i].waddr == ld_waddr)) begin
                    hit[b]           = 1'b1;
                    fwd_data[8*b +: 8] = snap[i].data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld_valid) begin
            hit_q <= hit;
            fwd_q <= fwd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= ld_valid;
        end
    end

    // ------------------------------------------------------------
    // Merge with the RAM word in the response cycle
    // ------------------------------------------------------------
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            ld_rdata[8*b +: 8] = hit_q[b] ? fwd_q[8*b +: 8] : ram_rdata[8*b +: 8];
        end
    end

    assign ld_rsp_valid = rsp_valid_q;

endmodule

//--- hdl/store_buffer.sv
module store_buffer
    import sb_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,

    // Push side, from the aligner.
    input  logic      push_valid,
    input  sb_entry_t push_entry,
    output logic      push_ready,

    // Drain side, towards the data RAM.
    output logic      drain_valid,
    output sb_entry_t drain_entry,
    input  logic      drain_ready,

    output sb_snap_t  snap,
    output logic      full
);

    logic [SB_PTR_W-1:0] head_q;   // Next slot to write.
    logic [SB_PTR_W-1:0] tail_q;   // Oldest entry.
    logic [SB_CNT_W-1:0] cnt_q;
    logic [SB_PTR_W-1:0] head_d;
    logic [SB_PTR_W-1:0] tail_d;
    logic [SB_CNT_W-1:0] cnt_d;

    sb_entry_t [SB_SIZE-1:0] entries;

    logic push;
    logic pop;

    // ------------------------------------------------------------
    // Handshakes
    // ------------------------------------------------------------
    assign push = push_valid & push_ready & ~flush;  // Dropped during flush.
    assign pop  = drain_valid & drain_ready;

    assign push_ready = (cnt_q < SB_CNT_W'(SB_SIZE));
    assign full       = (cnt_q == SB_CNT_W'(SB_SIZE));

    assign drain_entry = entries[tail_q];
    assign drain_valid = entries[tail_q].valid;

    // ------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------
    always_comb begin
        head_d = head_q + SB_PTR_W'(push);
        tail_d = tail_q + SB_PTR_W'(pop);
        cnt_d  = cnt_q + SB_CNT_W'(push) - SB_CNT_W'(pop);
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_q <= '0;
            tail_q <= '0;
            cnt_q  <= '0;
        end else begin
            head_q <= head_d;
            tail_q <= tail_d;
            cnt_q  <= cnt_d;
        end
    end

    // ------------------------------------------------------------
    // Entry storage
    // ------------------------------------------------------------
    // Head and tail only meet when the buffer is empty or full,
    // and then at most one of push and pop can fire.
    always_ff @(posedge clk) begin
        for (int i = 0; i < SB_SIZE; i++) begin
            if (rst || flush) begin
                entries[i] <= '0;
            end else if (push && (SB_PTR_W'(i) == head_q)) begin
                entries[i] <= push_entry;
            end else if (pop && (SB_PTR_W'(i) == tail_q)) begin
                entries[i].valid <= 1'b0;  // Slot freed.
            end
        end
    end

    // Rotate so the snapshot starts at the oldest entry.
    always_comb begin
        for (int i = 0; i < SB_SIZE; i++) begin
            snap[i] = entries[SB_PTR_W'(i) + tail_q];
        end
    end

endmodule

//--- hdl/store_align.sv
module store_align
    import sb_pkg::*;
(
    input  logic      st_valid,
    input  st_req_t   st_req,
    output logic      st_ready,
    output logic      st_misaligned,
    output logic      push_valid,
    output sb_entry_t push_entry,
    input  logic      push_ready
);

    logic [1:0]  offset;
    logic [3:0]  strb;
    logic [31:0] lane_data;
    logic        misaligned;

    assign offset = st_req.addr[1:0];

    // Size and offset decode.
    always_comb begin
        strb       = 4'b0000;
        lane_data  = st_req.data;
        misaligned = 1'b0;
        case (st_req.size)
            ST_BYTE: begin
                strb      = 4'b0001 << offset;
                lane_data = {4{st_req.data[7:0]}};  // Byte copied to all lanes.
            end
            ST_HALF: begin
                strb       = 4'b0011 << offset;
                lane_data  = {2{st_req.data[15:0]}};
                misaligned = offset[0];
            end
            default: begin
                strb       = 4'b1111;
                misaligned = (offset != 2'b00);
            end
        endcase
    end

    // A rejected store is still consumed, so it reports only when taken.
    assign st_ready      = push_ready;
    assign st_misaligned = st_valid & push_ready & misaligned;
    assign push_valid    = st_valid & ~misaligned;

    always_comb begin
        push_entry.waddr = st_req.addr[31:2];
        push_entry.data  = lane_data;
        push_entry.strb  = strb;
        push_entry.valid = 1'b1;
    end

endmodule

//--- hdl/sb_pkg.sv
package sb_pkg;

    // ------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------
    localparam int unsigned SB_SIZE   = 4;   // Store buffer entries.
    localparam int unsigned SB_PTR_W  = 2;   // Head and tail pointer width.
    localparam int unsigned SB_CNT_W  = 3;   // Occupancy counter, 0 to SB_SIZE.
    localparam int unsigned RAM_WORDS = 64;  // Data RAM depth in words.
    localparam int unsigned RAM_IDX_W = 6;   // Word index into the data RAM.

    // ------------------------------------------------------------
    // Store request from the pipeline
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        ST_BYTE = 2'd0,
        ST_HALF = 2'd1,
        ST_WORD = 2'd2
    } st_size_e;

    // Data is right-justified, the aligner moves it into its lanes.
    typedef struct packed {
        logic [31:0] addr;   // Byte address.
        logic [31:0] data;
        st_size_e    size;
    } st_req_t;

    // ------------------------------------------------------------
    // Buffer entry and snapshot
    // ------------------------------------------------------------
    typedef struct packed {
        logic [29:0] waddr;  // Word address.
        logic [31:0] data;   // Lane-placed data.
        logic [3:0]  strb;   // One bit per byte lane.
        logic        valid;
    } sb_entry_t;

    // Index 0 is the oldest entry, SB_SIZE-1 the newest slot.
    typedef sb_entry_t [SB_SIZE-1:0] sb_snap_t;

endpackage
